//--- Makefile
# Verilator build and run for the beamforming combiner testbench
# override any variable on the command line, for example: make TOP=beamform_tb

VERILATOR  ?= verilator
TOP        ?= beamform_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= TEST RESULT: PASS
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) beamform_config.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the verdict comes from the log, so a missing pass line fails the target
run: $(BINARY)
	rm -f $(LOG)
	-./$(BINARY) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- beamform_config.svh
/* beamforming combiner configuration
   lane count, sample and weight widths, and the weighter pipeline depth */
`ifndef BEAMFORM_CONFIG_SVH
`define BEAMFORM_CONFIG_SVH

// complex samples carried in one beat of each channel
`define BF_LANES 8

// width of the real or imaginary part of a sample
`define BF_SAMPLE_W 16

// width of the real or imaginary part of a channel weight
`define BF_WEIGHT_W 8

// weights are fixed point with this many fraction bits, so a weight stays below one
// and the complex product is shifted right by the same amount
`define BF_WEIGHT_FRAC 7

// cycles through the channel weighter
// the beam summer adds one more register on top of this
`define BF_WEIGHTER_STAGES 2

`endif

//--- sim.f
+incdir+.
src/beamform_pkg.sv
src/channel_weighter.sv
src/beam_summer.sv
src/beamform_combiner.sv
testbench/beamform_tb.sv

//--- src/beam_summer.sv
/* beam summer
   adds two weighted channel beats lane by lane and saturates the sums to sample width */
`timescale 1ns/1ns
`default_nettype none

`include "beamform_config.svh"

module beam_summer (
    input  wire logic                          clock,
    input  wire logic                          resetn,
    input  wire logic                          a_valid,
    input  wire beamform_pkg::weighted_beat_t  a,
    input  wire logic                          b_valid,
    input  wire beamform_pkg::weighted_beat_t  b,
    output logic                               out_valid,
    output logic                               out_last,
    output beamform_pkg::cplx_beat_t           out_beat
);

    // one bit wider than a weighted part so the sum of two never wraps
    typedef logic signed [`BF_SAMPLE_W+2:0] sum_t;

    localparam sum_t sum_max = sum_t'(2 ** (`BF_SAMPLE_W - 1) - 1);
    localparam sum_t sum_min = -sum_t'(2 ** (`BF_SAMPLE_W - 1));

    beamform_pkg::cplx_beat_t sum_beat;

    // clamp a wide sum into the range of one sample part
    function automatic beamform_pkg::sample_t saturate(input sum_t value);
        if (value > sum_max) begin
            return beamform_pkg::sample_t'(sum_max);
        end else if (value < sum_min) begin
            return beamform_pkg::sample_t'(sum_min);
        end
        return beamform_pkg::sample_t'(value);
    endfunction

    // both operands are sign extended before the add
    always_comb begin
        for (int i = 0; i < `BF_LANES; i++) begin
            sum_beat[i].re = saturate(sum_t'(a.lane[i].re) + sum_t'(b.lane[i].re));
            sum_beat[i].im = saturate(sum_t'(a.lane[i].im) + sum_t'(b.lane[i].im));
        end
    end

    // the output register clears the beat and last on any cycle without valid
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_beat  <= '0;
        end else if (a_valid) begin
            out_valid <= 1'b1;
            out_last  <= a.last;
            out_beat  <= sum_beat;
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_beat  <= '0;
        end
    end

    // both weighters see the same strobe, so their outputs must line up
    a_valid_aligned: assert property (
        @(posedge clock) disable iff (!resetn)
        a_valid == b_valid
    ) else $error("beam summer inputs arrive on different cycles");

    // last is taken from channel a only, which is safe while the channels agree
    a_last_aligned: assert property (
        @(posedge clock) disable iff (!resetn)
        a_valid |-> (a.last == b.last)
    ) else $error("beam summer inputs disagree on the frame last flag");

endmodule

`default_nettype wire

//--- src/beamform_combiner.sv
/* two channel receive beamforming combiner
   weights each channel's beat by its complex weight and sums the channels */
`timescale 1ns/1ns
`default_nettype none

module beamform_combiner (
    input  wire logic                        clock,
    input  wire logic                        resetn,
    input  wire logic                        in_valid,
    input  wire logic                        in_last,
    input  wire beamform_pkg::cplx_beat_t    ch0_beat,
    input  wire beamform_pkg::cplx_beat_t    ch1_beat,
    input  wire beamform_pkg::cplx_weight_t  ch0_weight,
    input  wire beamform_pkg::cplx_weight_t  ch1_weight,
    output logic                             out_valid,
    output logic                             out_last,
    output beamform_pkg::cplx_beat_t         out_beat
);

    // weighted beats from each channel, two cycles behind the input strobe
    beamform_pkg::weighted_beat_t ch0_weighted;
    beamform_pkg::weighted_beat_t ch1_weighted;
    logic                         ch0_valid;
    logic                         ch1_valid;

    // both channels share the strobe and last flag, so they stay in lockstep
    channel_weighter u_weighter_ch0 (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .beat      (ch0_beat),
        .weight    (ch0_weight),
        .out_valid (ch0_valid),
        .weighted  (ch0_weighted)
    );

    channel_weighter u_weighter_ch1 (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .beat      (ch1_beat),
        .weight    (ch1_weight),
        .out_valid (ch1_valid),
        .weighted  (ch1_weighted)
    );

    // one more register here brings the total latency to three cycles
    beam_summer u_summer (
        .clock     (clock),
        .resetn    (resetn),
        .a_valid   (ch0_valid),
        .a         (ch0_weighted),
        .b_valid   (ch1_valid),
        .b         (ch1_weighted),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_beat  (out_beat)
    );

endmodule

`default_nettype wire

//--- src/beamform_pkg.sv
/* beamforming combiner types
   complex samples, weights and the weighted beats passed between pipeline stages */
`default_nettype none

`include "beamform_config.svh"

package beamform_pkg;

    // one signed part of an input or output sample
    typedef logic signed [`BF_SAMPLE_W-1:0] sample_t;

    // one signed part of a channel weight
    typedef logic signed [`BF_WEIGHT_W-1:0] coeff_t;

    // full precision product of one sample part and one weight part
    typedef logic signed [`BF_SAMPLE_W+`BF_WEIGHT_W-1:0] product_t;

    // a complex product part after the fraction shift
    // two bits wider than a sample, so the sum of two channels cannot wrap
    typedef logic signed [`BF_SAMPLE_W+1:0] weighted_t;

    typedef struct packed {
        coeff_t re;
        coeff_t im;
    } cplx_weight_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // lane 0 sits in the low bits of the beat
    typedef cplx_sample_t [`BF_LANES-1:0] cplx_beat_t;

    typedef struct packed {
        weighted_t re;
        weighted_t im;
    } weighted_pair_t;

    // one weighted channel beat on its way to the summer
    typedef struct packed {
        weighted_pair_t [`BF_LANES-1:0] lane;
        logic                           last;
    } weighted_beat_t;

endpackage

`default_nettype wire

//--- src/channel_weighter.sv
/* channel weighter
   multiplies every lane of one channel beat by the channel's complex weight */
`timescale 1ns/1ns
`default_nettype none

`include "beamform_config.svh"

module channel_weighter (
    input  wire logic                          clock,
    input  wire logic                          resetn,
    input  wire logic                          in_valid,
    input  wire logic                          in_last,
    input  wire beamform_pkg::cplx_beat_t      beat,
    input  wire beamform_pkg::cplx_weight_t    weight,
    output logic                               out_valid,
    output beamform_pkg::weighted_beat_t       weighted
);

    // the four partial products of one lane
    typedef struct packed {
        beamform_pkg::product_t rr;
        beamform_pkg::product_t ii;
        beamform_pkg::product_t ri;
        beamform_pkg::product_t ir;
    } partial_t;

    // one bit wider than a product, enough for the sum or difference of two
    typedef logic signed [`BF_SAMPLE_W+`BF_WEIGHT_W:0] acc_t;

    partial_t [`BF_LANES-1:0]                     partial_q;
    beamform_pkg::weighted_pair_t [`BF_LANES-1:0] lane_d;
    beamform_pkg::weighted_pair_t [`BF_LANES-1:0] lane_q;
    acc_t                                         acc_re [`BF_LANES];
    acc_t                                         acc_im [`BF_LANES];

    logic valid_q1;
    logic last_q1;
    logic last_q2;

    // stage one registers the signed partial products of every lane
    // the operands are signed, so the multiply extends them to the product width
    always_ff @(posedge clock) begin
        if (in_valid) begin
            for (int i = 0; i < `BF_LANES; i++) begin
                partial_q[i].rr <= beat[i].re * weight.re;
                partial_q[i].ii <= beat[i].im * weight.im;
                partial_q[i].ri <= beat[i].re * weight.im;
                partial_q[i].ir <= beat[i].im * weight.re;
            end
        end
    end

    // complex product per lane, then drop the weight's fraction bits
    // the arithmetic shift rounds toward negative infinity
    always_comb begin
        for (int i = 0; i < `BF_LANES; i++) begin
            acc_re[i] = acc_t'(partial_q[i].rr) - acc_t'(partial_q[i].ii);
            acc_im[i] = acc_t'(partial_q[i].ri) + acc_t'(partial_q[i].ir);
            lane_d[i].re = beamform_pkg::weighted_t'(acc_re[i] >>> `BF_WEIGHT_FRAC);
            lane_d[i].im = beamform_pkg::weighted_t'(acc_im[i] >>> `BF_WEIGHT_FRAC);
        end
    end

    // stage two holds the shifted products for the summer
    always_ff @(posedge clock) begin
        if (valid_q1) begin
            lane_q <= lane_d;
        end
    end

    // valid and last walk alongside the data through both stages
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q1  <= 1'b0;
            last_q1   <= 1'b0;
            out_valid <= 1'b0;
            last_q2   <= 1'b0;
        end else begin
            valid_q1  <= in_valid;
            last_q1   <= in_valid & in_last;
            out_valid <= valid_q1;
            last_q2   <= last_q1;
        end
    end

    assign weighted.lane = lane_q;
    assign weighted.last = last_q2;

    // every strobe leaves the weighter exactly two cycles later, and nothing else does
    a_weighter_latency: assert property (
        @(posedge clock) disable iff (!resetn)
        ($past(resetn, 1) && $past(resetn, 2)) |-> (out_valid == $past(in_valid, 2))
    ) else $error("channel weighter output valid does not follow input valid by 2 cycles");

endmodule

`default_nettype wire

//--- testbench/beamform_tb.sv
/* beamforming combiner testbench
   directed tests checked against a model of the weighting and combining rules */
`timescale 1ns/1ns
`default_nettype none

`include "beamform_config.svh"

module beamform_tb;

    localparam int clock_period = 40;
    localparam int reset_cycles = 4;
    localparam int idle_cycles = 10;
    // two weighter stages plus the summer register
    localparam int latency = `BF_WEIGHTER_STAGES + 1;
    // 1 single beat, 40 random beats, 16 back to back beats and 2 saturation beats
    localparam int total_beats = 59;
    localparam int drain_cycles = 8 * (latency + 2);
    localparam int cycle_limit = 4 * total_beats + reset_cycles + idle_cycles + drain_cycles;
    localparam int sample_max = 2 ** (`BF_SAMPLE_W - 1) - 1;
    localparam int sample_min = -(2 ** (`BF_SAMPLE_W - 1));

    // an expected output beat and the cycle count at which it must appear
    typedef struct packed {
        beamform_pkg::cplx_beat_t beat;
        logic                     last;
        int                       due;
    } expect_t;

    logic                       clock = 1'b0;
    logic                       resetn;
    logic                       in_valid;
    logic                       in_last;
    beamform_pkg::cplx_beat_t   ch0_beat;
    beamform_pkg::cplx_beat_t   ch1_beat;
    beamform_pkg::cplx_weight_t ch0_weight;
    beamform_pkg::cplx_weight_t ch1_weight;
    logic                       out_valid;
    logic                       out_last;
    beamform_pkg::cplx_beat_t   out_beat;

    int      cycle_count = 0;
    expect_t expect_q[$];

    beamform_combiner u_beamform_combiner (
        .clock      (clock),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .ch0_beat   (ch0_beat),
        .ch1_beat   (ch1_beat),
        .ch0_weight (ch0_weight),
        .ch1_weight (ch1_weight),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_beat   (out_beat)
    );

    always #(clock_period / 2) clock = ~clock;

    // counts rising edges and is read only on falling edges where it is stable
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic fail_and_stop(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        fail_and_stop($sformatf("MISMATCH at %0t ns: %s", $time, what));
    endtask

    always @(negedge clock) begin
        if (cycle_count >= cycle_limit) begin
            fail_and_stop($sformatf("timeout after %0d cycles, the tests never finished",
                                    cycle_count));
        end
    end

    // the weight's fraction bits are dropped with an arithmetic shift, so it rounds down
    function automatic int drop_fraction(input int full);
        return full >>> `BF_WEIGHT_FRAC;
    endfunction

    function automatic beamform_pkg::sample_t clamp_sample(input int value);
        if (value > sample_max) begin
            return beamform_pkg::sample_t'(sample_max);
        end else if (value < sample_min) begin
            return beamform_pkg::sample_t'(sample_min);
        end
        return beamform_pkg::sample_t'(value);
    endfunction

    // full precision complex weighting of both channels, then the saturated lane sum
    function automatic beamform_pkg::cplx_beat_t model_combine(
        input beamform_pkg::cplx_beat_t   beat0,
        input beamform_pkg::cplx_beat_t   beat1,
        input beamform_pkg::cplx_weight_t w0,
        input beamform_pkg::cplx_weight_t w1
    );
        beamform_pkg::cplx_beat_t result;
        int re0;
        int im0;
        int re1;
        int im1;
        for (int i = 0; i < `BF_LANES; i++) begin
            re0 = drop_fraction(int'(beat0[i].re) * int'(w0.re) - int'(beat0[i].im) * int'(w0.im));
            im0 = drop_fraction(int'(beat0[i].re) * int'(w0.im) + int'(beat0[i].im) * int'(w0.re));
            re1 = drop_fraction(int'(beat1[i].re) * int'(w1.re) - int'(beat1[i].im) * int'(w1.im));
            im1 = drop_fraction(int'(beat1[i].re) * int'(w1.im) + int'(beat1[i].im) * int'(w1.re));
            result[i].re = clamp_sample(re0 + re1);
            result[i].im = clamp_sample(im0 + im1);
        end
        return result;
    endfunction

    function automatic beamform_pkg::cplx_beat_t random_beat();
        beamform_pkg::cplx_beat_t beat;
        for (int i = 0; i < `BF_LANES; i++) begin
            beat[i].re = beamform_pkg::sample_t'($urandom);
            beat[i].im = beamform_pkg::sample_t'($urandom);
        end
        return beat;
    endfunction

    function automatic beamform_pkg::cplx_weight_t random_weight();
        beamform_pkg::cplx_weight_t weight;
        weight.re = beamform_pkg::coeff_t'($urandom);
        weight.im = beamform_pkg::coeff_t'($urandom);
        return weight;
    endfunction

    // every falling edge compares the outputs and checks a valid beat against the queue head
    always @(negedge clock) begin : check_output
        expect_t head;
        if (cycle_count > 0) begin
            if (out_valid) begin
                assert (expect_q.size() != 0)
                else fail_and_stop("output valid was high while no beat was expected");
                head = expect_q.pop_front();
                assert (cycle_count == head.due)
                else report_mismatch($sformatf("beat arrived on cycle %0d, due on cycle %0d",
                                               cycle_count, head.due));
                assert (out_last == head.last)
                else report_mismatch($sformatf("out_last is %0b, expected %0b",
                                               out_last, head.last));
                for (int i = 0; i < `BF_LANES; i++) begin
                    assert (out_beat[i].re == head.beat[i].re)
                    else report_mismatch($sformatf("lane %0d real got %0d expected %0d",
                                                   i, out_beat[i].re, head.beat[i].re));
                    assert (out_beat[i].im == head.beat[i].im)
                    else report_mismatch($sformatf("lane %0d imag got %0d expected %0d",
                                                   i, out_beat[i].im, head.beat[i].im));
                end
            end else begin
                // idle cycles must show a cleared beat and a low last flag
                assert (out_last == 1'b0)
                else report_mismatch("out_last is high while out_valid is low");
                assert (out_beat == '0)
                else report_mismatch("out_beat is not zero while out_valid is low");
            end
        end
    end

    task automatic send_beat(
        input beamform_pkg::cplx_beat_t   beat0,
        input beamform_pkg::cplx_beat_t   beat1,
        input beamform_pkg::cplx_weight_t w0,
        input beamform_pkg::cplx_weight_t w1,
        input logic                       last,
        input beamform_pkg::cplx_beat_t   expected
    );
        expect_t entry;
        @(negedge clock);
        ch0_beat   = beat0;
        ch1_beat   = beat1;
        ch0_weight = w0;
        ch1_weight = w1;
        in_last    = last;
        in_valid   = 1'b1;
        entry.beat = expected;
        entry.last = last;
        // the first of the three pipeline registers captures the beat on the next rising edge
        entry.due  = cycle_count + latency;
        expect_q.push_back(entry);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            in_valid   = 1'b0;
            in_last    = 1'b0;
            ch0_beat   = '0;
            ch1_beat   = '0;
            ch0_weight = '0;
            ch1_weight = '0;
        end
    endtask

    // waits for every queued beat, then stays quiet long enough to catch a stray one
    task automatic drain();
        idle(1);
        while (expect_q.size() != 0) begin
            @(posedge clock);
        end
        idle(latency + 1);
    endtask

    task automatic test_reset_idle();
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
        idle(idle_cycles);
    endtask

    task automatic test_single_channel();
        beamform_pkg::cplx_beat_t   beat0;
        beamform_pkg::cplx_beat_t   expected;
        beamform_pkg::cplx_weight_t half;
        beat0 = random_beat();
        // small negatives show the rounding toward negative infinity
        beat0[0].re = -16'sd1;
        beat0[0].im = -16'sd3;
        half.re = beamform_pkg::coeff_t'(64);
        half.im = '0;
        for (int i = 0; i < `BF_LANES; i++) begin
            expected[i].re = beat0[i].re >>> 1;
            expected[i].im = beat0[i].im >>> 1;
        end
        send_beat(beat0, random_beat(), half, '0, 1'b1, expected);
        drain();
    endtask

    task automatic test_random_frames();
        beamform_pkg::cplx_beat_t   beat0;
        beamform_pkg::cplx_beat_t   beat1;
        beamform_pkg::cplx_weight_t w0;
        beamform_pkg::cplx_weight_t w1;
        for (int k = 0; k < 40; k++) begin
            beat0 = random_beat();
            beat1 = random_beat();
            w0 = random_weight();
            w1 = random_weight();
            send_beat(beat0, beat1, w0, w1, (k % 8) == 7, model_combine(beat0, beat1, w0, w1));
            idle($urandom_range(3, 0));
        end
        drain();
    endtask

    task automatic test_back_to_back();
        beamform_pkg::cplx_beat_t   beat0;
        beamform_pkg::cplx_beat_t   beat1;
        beamform_pkg::cplx_weight_t w0;
        beamform_pkg::cplx_weight_t w1;
        for (int k = 0; k < 16; k++) begin
            beat0 = random_beat();
            beat1 = random_beat();
            w0 = random_weight();
            w1 = random_weight();
            send_beat(beat0, beat1, w0, w1, (k % 4) == 3, model_combine(beat0, beat1, w0, w1));
        end
        drain();
    endtask

    task automatic test_saturation();
        beamform_pkg::cplx_beat_t   low_beat;
        beamform_pkg::cplx_beat_t   high_beat;
        beamform_pkg::cplx_beat_t   clamp_high;
        beamform_pkg::cplx_beat_t   clamp_low;
        beamform_pkg::cplx_weight_t minus_one;
        minus_one.re = beamform_pkg::coeff_t'(-128);
        minus_one.im = '0;
        for (int i = 0; i < `BF_LANES; i++) begin
            low_beat[i].re   = beamform_pkg::sample_t'(sample_min);
            low_beat[i].im   = beamform_pkg::sample_t'(sample_min);
            high_beat[i].re  = beamform_pkg::sample_t'(sample_max);
            high_beat[i].im  = beamform_pkg::sample_t'(sample_max);
            clamp_high[i].re = beamform_pkg::sample_t'(sample_max);
            clamp_high[i].im = beamform_pkg::sample_t'(sample_max);
            clamp_low[i].re  = beamform_pkg::sample_t'(sample_min);
            clamp_low[i].im  = beamform_pkg::sample_t'(sample_min);
        end
        // each channel gives +32768 and the sum of 65536 clamps to the top
        send_beat(low_beat, low_beat, minus_one, minus_one, 1'b0, clamp_high);
        // each channel gives -32767 and the sum of -65534 clamps to the bottom
        send_beat(high_beat, high_beat, minus_one, minus_one, 1'b1, clamp_low);
        drain();
    endtask

    initial begin
        void'($urandom(32'hb316_dac6));
        resetn     = 1'b0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        ch0_beat   = '0;
        ch1_beat   = '0;
        ch0_weight = '0;
        ch1_weight = '0;
        test_reset_idle();
        test_single_channel();
        test_random_frames();
        test_back_to_back();
        test_saturation();
        if (expect_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_and_stop("expected beats were still waiting when the tests ended");
        end
    end

endmodule

`default_nettype wire
